// File: design/core_pkg.sv
// Core uncore package with widths, bus structs, register map and IO FSM states
package core_pkg;

	localparam int THREADS_PER_CORE = 4;	// Hardware threads per core
	localparam int NUM_COUNTERS = 4;	// Event counter slots

	typedef logic [31:0] scalar_t;	// Data or address word
	typedef logic [$clog2(THREADS_PER_CORE)-1:0] thread_idx_t;	// Thread number
	typedef logic [THREADS_PER_CORE-1:0] thread_bitmap_t;	// One bit per thread
	typedef logic [3:0] creg_idx_t;	// Control register number

	// Upper address half that maps to the control registers
	localparam logic [15:0] CREG_REGION = 16'hffff;

	localparam creg_idx_t CR_THREAD_ENABLE = 4'd0;	// Read-write
	localparam creg_idx_t CR_CORE_ID = 4'd1;	// Read-only
	localparam creg_idx_t CR_PERF_BASE = 4'd8;	// Counter n at base + n

	localparam int EV_CREG_ACCESS = 0;	// Any control register access
	localparam int EV_IO_READ = 1;	// IO load accepted
	localparam int EV_IO_WRITE = 2;	// IO store accepted
	localparam int EV_IO_STALL = 3;	// IO request held off by device

	// Core access request, 67 bits
	typedef struct packed {
		thread_idx_t thread;	// Issuing thread
		scalar_t addr;
		logic store;	// 1 = store, 0 = load
		scalar_t data;	// Store data
	} access_req_t;

	// Core access response, 34 bits
	typedef struct packed {
		thread_idx_t thread;
		scalar_t data;	// Load data or echoed store data
	} access_rsp_t;

	// External IO bus request
	typedef struct packed {
		thread_idx_t thread;
		scalar_t addr;
		logic store;
		scalar_t data;
	} io_req_t;

	// External IO bus response
	typedef struct packed {
		scalar_t data;
	} io_rsp_t;

	// IO request sequencing
	typedef enum logic [1:0] {
		IO_IDLE,	// Nothing outstanding
		IO_ISSUE,	// Request on the bus, device not ready yet
		IO_WAIT	// Request taken, waiting for response
	} io_state_t;

endpackage

// File: design/access_router.sv
// Access router that decodes core accesses to control registers or IO and returns responses
`timescale 1ns/1ns

module access_router (
	input clk,
	input rst_n,
	input core_pkg::access_req_t req,
	input req_valid,
	output logic req_ready,
	output core_pkg::access_rsp_t rsp,
	output logic rsp_valid,
	input rsp_ready,
	output core_pkg::io_req_t io_fwd,
	output logic io_fwd_valid,
	input io_fwd_ready,
	input io_done,
	input core_pkg::scalar_t io_done_data,
	output logic creg_en,
	output logic creg_store,
	output core_pkg::creg_idx_t creg_idx,
	output core_pkg::scalar_t creg_wdata,
	input core_pkg::scalar_t creg_rdata,
	output logic [core_pkg::NUM_COUNTERS-1:0] perf_event
);

	logic busy;	// Access in progress or response held
	logic accept;
	logic is_creg;

	assign req_ready = !busy;	// One access at a time
	assign accept = req_valid && req_ready;
	assign is_creg = req.addr[31:16] == core_pkg::CREG_REGION;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			busy <= 1'b0;
			creg_en <= 1'b0;
			io_fwd_valid <= 1'b0;
			rsp_valid <= 1'b0;
			perf_event <= '0;
		end else begin
			if (accept)
				busy <= 1'b1;
			else if (rsp_valid && rsp_ready)
				busy <= 1'b0;	// Free once requester takes response

			creg_en <= accept && is_creg;	// Register access one cycle after accept

			if (accept && !is_creg)
				io_fwd_valid <= 1'b1;
			else if (io_fwd_ready)
				io_fwd_valid <= 1'b0;	// Dropped when device takes it

			if (creg_en || io_done)
				rsp_valid <= 1'b1;
			else if (rsp_ready)
				rsp_valid <= 1'b0;

			// Pulses lag acceptance by one cycle
			perf_event[core_pkg::EV_CREG_ACCESS] <= accept && is_creg;
			perf_event[core_pkg::EV_IO_READ] <= accept && !is_creg && !req.store;
			perf_event[core_pkg::EV_IO_WRITE] <= accept && !is_creg && req.store;
			perf_event[core_pkg::EV_IO_STALL] <= io_fwd_valid && !io_fwd_ready;
		end
	end

	// Payload capture, held steady while busy
	always_ff @(posedge clk) begin
		if (accept) begin
			rsp.thread <= req.thread;
			creg_store <= req.store;
			creg_idx <= req.addr[5:2];	// Word-aligned register offset
			creg_wdata <= req.data;
			io_fwd.thread <= req.thread;
			io_fwd.addr <= req.addr;
			io_fwd.store <= req.store;
			io_fwd.data <= req.data;
		end

		if (creg_en)
			rsp.data <= creg_store ? creg_wdata : creg_rdata;	// Store echoes its data
		else if (io_done)
			rsp.data <= io_done_data;
	end

endmodule

// File: design/control_registers.sv
// Control register file with thread enables, core identifier, counter views and halt
`timescale 1ns/1ns

module control_registers #(
	parameter int CORE_ID = 0
) (
	input clk,
	input rst_n,
	input creg_en,
	input creg_store,
	input core_pkg::creg_idx_t creg_idx,
	input core_pkg::scalar_t creg_wdata,
	output core_pkg::scalar_t creg_rdata,
	input core_pkg::scalar_t [core_pkg::NUM_COUNTERS-1:0] counter_values,
	output logic processor_halt
);

	core_pkg::thread_bitmap_t thread_enable;	// One bit per runnable thread
	logic enable_write;

	// Only the enable bitmap is writable
	assign enable_write = creg_en && creg_store && creg_idx == core_pkg::CR_THREAD_ENABLE;

	always_ff @(posedge clk) begin
		if (!rst_n)
			thread_enable <= core_pkg::thread_bitmap_t'(1);	// Thread 0 runs out of reset
		else if (enable_write)
			thread_enable <= creg_wdata[core_pkg::THREADS_PER_CORE-1:0];
	end

	// Read mux, unmapped indices return zero
	always_comb begin
		creg_rdata = '0;
		case (creg_idx)
			core_pkg::CR_THREAD_ENABLE:
				creg_rdata = core_pkg::scalar_t'(thread_enable);	// Zero-extended bitmap
			core_pkg::CR_CORE_ID:
				creg_rdata = core_pkg::scalar_t'(CORE_ID);
			default: begin
				for (int n = 0; n < core_pkg::NUM_COUNTERS; n++) begin
					if (creg_idx == core_pkg::creg_idx_t'(core_pkg::CR_PERF_BASE + n))
						creg_rdata = counter_values[n];	// Counter window
				end
			end
		endcase
	end

	assign processor_halt = thread_enable == '0;	// No thread left running

endmodule

// File: design/io_request_fsm.sv
// IO request sequencer that issues one bus request and collects its response
`timescale 1ns/1ns

module io_request_fsm (
	input clk,
	input rst_n,
	input core_pkg::io_req_t io_fwd,
	input io_fwd_valid,
	output logic io_fwd_ready,
	output core_pkg::io_req_t io_request,
	output logic io_request_valid,
	input io_ready,
	input core_pkg::io_rsp_t io_response,
	input io_response_valid,
	output logic io_done,
	output core_pkg::scalar_t io_done_data
);

	core_pkg::io_state_t state;
	core_pkg::io_req_t req_q;	// Copy of the request in flight
	logic issue_phase;	// Request may be on the bus

	assign issue_phase = state == core_pkg::IO_IDLE || state == core_pkg::IO_ISSUE;

	// First cycle goes straight out from the router register
	assign io_request = state == core_pkg::IO_IDLE ? io_fwd : req_q;
	assign io_request_valid = (state == core_pkg::IO_IDLE && io_fwd_valid)
		|| state == core_pkg::IO_ISSUE;

	// Router request completes together with the bus transfer
	assign io_fwd_ready = issue_phase && io_ready;

	// Completion strobe in the cycle the response is sampled
	assign io_done = state == core_pkg::IO_WAIT && io_response_valid;
	assign io_done_data = req_q.store ? req_q.data : io_response.data;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= core_pkg::IO_IDLE;
		end else begin
			case (state)
				core_pkg::IO_IDLE: begin
					if (io_fwd_valid) begin
						if (io_ready)
							state <= core_pkg::IO_WAIT;	// Taken on first cycle
						else
							state <= core_pkg::IO_ISSUE;
					end
				end

				core_pkg::IO_ISSUE: begin
					if (io_ready)
						state <= core_pkg::IO_WAIT;
				end

				core_pkg::IO_WAIT: begin
					if (io_response_valid)
						state <= core_pkg::IO_IDLE;	// Late responses ignored in idle
				end

				default:
					state <= core_pkg::IO_IDLE;
			endcase
		end
	end

	// Latch on launch
	always_ff @(posedge clk) begin
		if (state == core_pkg::IO_IDLE && io_fwd_valid)
			req_q <= io_fwd;
	end

endmodule

// File: design/performance_counters.sv
// Free-running event counters, one per event slot
`timescale 1ns/1ns

module performance_counters (
	input clk,
	input rst_n,
	input [core_pkg::NUM_COUNTERS-1:0] perf_event,
	output core_pkg::scalar_t [core_pkg::NUM_COUNTERS-1:0] counter_values
);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			counter_values <= '0;
		end else begin
			for (int i = 0; i < core_pkg::NUM_COUNTERS; i++) begin
				if (perf_event[i])
					counter_values[i] <= counter_values[i] + 32'd1;	// Wraps at 2^32
			end
		end
	end

endmodule

// File: design/core_uncore.sv
// Uncore top level joining access routing, control registers, IO path and counters
`timescale 1ns/1ns

module core_uncore #(
	parameter int CORE_ID = 0
) (
	input clk,
	input rst_n,

	// Core access port
	input core_pkg::access_req_t req,
	input req_valid,
	output logic req_ready,
	output core_pkg::access_rsp_t rsp,
	output logic rsp_valid,
	input rsp_ready,

	// Non-cacheable IO bus
	output core_pkg::io_req_t io_request,
	output logic io_request_valid,
	input io_ready,
	input core_pkg::io_rsp_t io_response,
	input io_response_valid,

	output logic processor_halt
);

	core_pkg::io_req_t io_fwd;	// Router to IO FSM
	logic io_fwd_valid;
	logic io_fwd_ready;
	logic io_done;	// IO completion strobe
	core_pkg::scalar_t io_done_data;
	logic creg_en;
	logic creg_store;
	core_pkg::creg_idx_t creg_idx;
	core_pkg::scalar_t creg_wdata;
	core_pkg::scalar_t creg_rdata;
	logic [core_pkg::NUM_COUNTERS-1:0] perf_event;	// One pulse per slot
	core_pkg::scalar_t [core_pkg::NUM_COUNTERS-1:0] counter_values;

	access_router access_router_inst (
		.clk(clk),
		.rst_n(rst_n),
		.req(req),
		.req_valid(req_valid),
		.req_ready(req_ready),
		.rsp(rsp),
		.rsp_valid(rsp_valid),
		.rsp_ready(rsp_ready),
		.io_fwd(io_fwd),
		.io_fwd_valid(io_fwd_valid),
		.io_fwd_ready(io_fwd_ready),
		.io_done(io_done),
		.io_done_data(io_done_data),
		.creg_en(creg_en),
		.creg_store(creg_store),
		.creg_idx(creg_idx),
		.creg_wdata(creg_wdata),
		.creg_rdata(creg_rdata),
		.perf_event(perf_event)
	);

	control_registers #(.CORE_ID(CORE_ID)) control_registers_inst (
		.clk(clk),
		.rst_n(rst_n),
		.creg_en(creg_en),
		.creg_store(creg_store),
		.creg_idx(creg_idx),
		.creg_wdata(creg_wdata),
		.creg_rdata(creg_rdata),
		.counter_values(counter_values),
		.processor_halt(processor_halt)
	);

	io_request_fsm io_request_fsm_inst (
		.clk(clk),
		.rst_n(rst_n),
		.io_fwd(io_fwd),
		.io_fwd_valid(io_fwd_valid),
		.io_fwd_ready(io_fwd_ready),
		.io_request(io_request),
		.io_request_valid(io_request_valid),
		.io_ready(io_ready),
		.io_response(io_response),
		.io_response_valid(io_response_valid),
		.io_done(io_done),
		.io_done_data(io_done_data)
	);

	performance_counters performance_counters_inst (
		.clk(clk),
		.rst_n(rst_n),
		.perf_event(perf_event),
		.counter_values(counter_values)
	);

endmodule

// File: test/core_uncore_tb.sv
// Testbench for the uncore with an IO device model, access stimulus and counter checks
`timescale 1ns/1ns

module core_uncore_tb;

	localparam int CORE_ID = 3;	// Value expected back from the ID register
	localparam int TIMEOUT_CYCLES = 200;	// Per wait loop
	localparam int IO_ACCESSES = 20;

	logic clk = 1'b0;
	logic rst_n;
	core_pkg::access_req_t req;
	logic req_valid;
	logic req_ready;
	core_pkg::access_rsp_t rsp;
	logic rsp_valid;
	logic rsp_ready;
	core_pkg::io_req_t io_request;
	logic io_request_valid;
	logic io_ready;
	core_pkg::io_rsp_t io_response;
	logic io_response_valid;
	logic processor_halt;

	integer seed = 79380;
	int mismatch_count = 0;
	int protocol_count = 0;
	int timeout_count = 0;
	bit aborted = 1'b0;	// Set by the first timeout, later waits fall through

	// Port-side tallies, compared with the counters
	int creg_tally = 0;
	int io_load_tally = 0;
	int io_store_tally = 0;
	int stall_tally = 0;
	int io_transfer_count = 0;

	core_pkg::io_req_t expected_io;	// Request the device should see next
	core_pkg::scalar_t shadow_mem [core_pkg::scalar_t];	// Expected device contents
	core_pkg::scalar_t device_mem [core_pkg::scalar_t];	// Device storage
	bit resp_pending;
	int resp_wait;
	int ready_wait;
	core_pkg::scalar_t resp_data;

	core_uncore #(.CORE_ID(CORE_ID)) core_uncore_inst (
		.clk(clk),
		.rst_n(rst_n),
		.req(req),
		.req_valid(req_valid),
		.req_ready(req_ready),
		.rsp(rsp),
		.rsp_valid(rsp_valid),
		.rsp_ready(rsp_ready),
		.io_request(io_request),
		.io_request_valid(io_request_valid),
		.io_ready(io_ready),
		.io_response(io_response),
		.io_response_valid(io_response_valid),
		.processor_halt(processor_halt)
	);

	always #20 clk = ~clk;	// 40 ns period

	function automatic int rand_range(input int n);
		return {$random(seed)} % n;
	endfunction

	task automatic check_value(input string test_name, input core_pkg::scalar_t expected,
		input core_pkg::scalar_t actual);
		if (!aborted) begin
			assert (actual === expected) else begin
				mismatch_count++;
				$display("Mismatch in %s: expected %h, actual %h", test_name, expected, actual);
			end
		end
	endtask

	task automatic report_timeout(input string what);
		$display("Timeout: %s", what);
		timeout_count++;
		aborted = 1'b1;
	endtask

	// Handshake rules on the DUT outputs
	assert property (@(posedge clk) disable iff (!rst_n)
		io_request_valid && !io_ready |=> io_request_valid)
	else begin
		protocol_count++;
		$display("io_request_valid dropped before the device was ready");
	end

	assert property (@(posedge clk) disable iff (!rst_n)
		io_request_valid && !io_ready |=> $stable(io_request))
	else begin
		protocol_count++;
		$display("io_request payload changed while waiting for io_ready");
	end

	assert property (@(posedge clk) disable iff (!rst_n)
		rsp_valid && !rsp_ready |=> rsp_valid)
	else begin
		protocol_count++;
		$display("rsp_valid dropped before the response was taken");
	end

	assert property (@(posedge clk) disable iff (!rst_n)
		rsp_valid && !rsp_ready |=> $stable(rsp))
	else begin
		protocol_count++;
		$display("rsp payload changed while waiting for rsp_ready");
	end

	// Port monitor, values are steady at the falling edge
	always @(negedge clk) begin
		if (rst_n) begin
			if (req_valid && req_ready) begin
				if (req.addr[31:16] == core_pkg::CREG_REGION)
					creg_tally++;
				else if (req.store)
					io_store_tally++;
				else
					io_load_tally++;
			end
			if (io_request_valid && !io_ready)
				stall_tally++;	// Device holding off a request
		end
	end

	// IO device with random ready and response delays
	always @(posedge clk) begin
		if (!rst_n) begin
			io_ready <= 1'b0;
			io_response_valid <= 1'b0;
			resp_pending <= 1'b0;
			ready_wait <= rand_range(4);
		end else begin
			io_response_valid <= 1'b0;	// Single-cycle response pulse
			if (resp_pending) begin
				if (resp_wait == 0) begin
					io_response_valid <= 1'b1;
					io_response.data <= resp_data;
					resp_pending <= 1'b0;
				end else begin
					resp_wait <= resp_wait - 1;
				end
			end
			if (io_request_valid && io_ready) begin
				io_transfer_count++;
				check_value("io request thread", core_pkg::scalar_t'(expected_io.thread),
					core_pkg::scalar_t'(io_request.thread));
				check_value("io request addr", expected_io.addr, io_request.addr);
				check_value("io request store", core_pkg::scalar_t'(expected_io.store),
					core_pkg::scalar_t'(io_request.store));
				check_value("io request data", expected_io.data, io_request.data);
				if (io_request.store) begin
					device_mem[io_request.addr] = io_request.data;
					resp_data <= '0;	// Store data must come from the core
				end else if (device_mem.exists(io_request.addr)) begin
					resp_data <= device_mem[io_request.addr];
				end else begin
					resp_data <= ~io_request.addr;	// Unwritten location
				end
				resp_pending <= 1'b1;
				resp_wait <= rand_range(4);
				io_ready <= rand_range(2);	// Sometimes stays ready for the next one
				ready_wait <= rand_range(4);
			end else if (io_request_valid) begin
				if (ready_wait == 0)
					io_ready <= 1'b1;
				else
					ready_wait <= ready_wait - 1;
			end
		end
	end

	task automatic issue_access(input core_pkg::access_req_t r);
		int cycles;
		bit accepted;
		cycles = 0;
		accepted = 1'b0;
		@(posedge clk);
		req <= r;
		req_valid <= 1'b1;
		while (!accepted && !aborted) begin
			@(negedge clk);
			if (req_ready) begin
				accepted = 1'b1;	// Transfer on the coming edge
			end else begin
				cycles++;
				if (cycles > TIMEOUT_CYCLES)
					report_timeout("req_ready stayed low");
			end
		end
		@(posedge clk);
		req_valid <= 1'b0;
	endtask

	task automatic collect_response(input bit backpressure, output core_pkg::access_rsp_t r);
		int cycles;
		bit taken;
		r = '0;
		cycles = 0;
		taken = 1'b0;
		while (!taken && !aborted) begin
			@(posedge clk);
			rsp_ready <= backpressure ? rand_range(2) : 1'b1;
			@(negedge clk);
			if (rsp_valid && rsp_ready) begin
				r = rsp;
				taken = 1'b1;
			end else begin
				cycles++;
				if (cycles > TIMEOUT_CYCLES)
					report_timeout("no response on rsp_valid");
			end
		end
		@(posedge clk);
		rsp_ready <= 1'b0;
	endtask

	task automatic creg_access(input string name, input core_pkg::creg_idx_t idx,
		input bit store, input core_pkg::scalar_t data, input core_pkg::scalar_t expected);
		core_pkg::access_req_t r;
		core_pkg::access_rsp_t result;
		r.thread = core_pkg::thread_idx_t'(rand_range(core_pkg::THREADS_PER_CORE));
		r.addr = {core_pkg::CREG_REGION, 10'd0, idx, 2'b00};
		r.store = store;
		r.data = data;
		issue_access(r);
		collect_response(1'b0, result);
		check_value({name, " thread"}, core_pkg::scalar_t'(r.thread),
			core_pkg::scalar_t'(result.thread));
		check_value({name, " data"}, expected, result.data);
	endtask

	task automatic io_access(input int index);
		core_pkg::access_req_t r;
		core_pkg::access_rsp_t result;
		core_pkg::scalar_t expected_data;
		int transfers_before;
		string name;
		name = $sformatf("io access %0d", index);
		r.thread = core_pkg::thread_idx_t'(rand_range(core_pkg::THREADS_PER_CORE));
		r.addr = 32'h4000_0000 | (core_pkg::scalar_t'(rand_range(8)) << 2);	// Small pool
		r.store = rand_range(2);
		r.data = $random(seed);
		if (r.store) begin
			shadow_mem[r.addr] = r.data;
			expected_data = r.data;	// Store echoes its data
		end else if (shadow_mem.exists(r.addr)) begin
			expected_data = shadow_mem[r.addr];
		end else begin
			expected_data = ~r.addr;
		end
		expected_io.thread = r.thread;
		expected_io.addr = r.addr;
		expected_io.store = r.store;
		expected_io.data = r.data;
		transfers_before = io_transfer_count;
		issue_access(r);
		collect_response(1'b1, result);
		check_value({name, " thread"}, core_pkg::scalar_t'(r.thread),
			core_pkg::scalar_t'(result.thread));
		check_value({name, " data"}, expected_data, result.data);
		check_value({name, " bus transfers"}, transfers_before + 1, io_transfer_count);
	endtask

	initial begin
		core_pkg::scalar_t bitmap;
		int expected_count [core_pkg::NUM_COUNTERS];
		rst_n = 1'b0;
		req = '0;
		req_valid = 1'b0;
		rsp_ready = 1'b0;
		io_ready = 1'b0;
		io_response = '0;
		io_response_valid = 1'b0;
		repeat (10) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);

		// Reset state
		check_value("reset halt", 0, core_pkg::scalar_t'(processor_halt));
		check_value("reset rsp_valid", 0, core_pkg::scalar_t'(rsp_valid));
		check_value("reset io_request_valid", 0, core_pkg::scalar_t'(io_request_valid));
		check_value("reset req_ready", 1, core_pkg::scalar_t'(req_ready));
		creg_access("reset enable read", core_pkg::CR_THREAD_ENABLE, 1'b0, '0, 1);

		creg_access("core id read", core_pkg::CR_CORE_ID, 1'b0, '0, CORE_ID);
		creg_access("core id store", core_pkg::CR_CORE_ID, 1'b1, 32'h55, 32'h55);
		creg_access("core id after store", core_pkg::CR_CORE_ID, 1'b0, '0, CORE_ID);

		// Thread enable and halt
		bitmap = rand_range(15) + 1;
		creg_access("enable store", core_pkg::CR_THREAD_ENABLE, 1'b1, bitmap, bitmap);
		creg_access("enable readback", core_pkg::CR_THREAD_ENABLE, 1'b0, '0, bitmap);
		@(negedge clk);
		check_value("halt with threads", 0, core_pkg::scalar_t'(processor_halt));
		creg_access("enable clear", core_pkg::CR_THREAD_ENABLE, 1'b1, '0, '0);
		@(negedge clk);
		check_value("halt with none", 1, core_pkg::scalar_t'(processor_halt));
		bitmap = rand_range(15) + 1;
		creg_access("enable restore", core_pkg::CR_THREAD_ENABLE, 1'b1, bitmap, bitmap);
		@(negedge clk);
		check_value("halt after restore", 0, core_pkg::scalar_t'(processor_halt));

		for (int i = 0; i < IO_ACCESSES; i++)
			io_access(i);

		// Counters hold the tallies seen at acceptance
		for (int n = 0; n < core_pkg::NUM_COUNTERS; n++) begin
			expected_count[core_pkg::EV_CREG_ACCESS] = creg_tally;
			expected_count[core_pkg::EV_IO_READ] = io_load_tally;
			expected_count[core_pkg::EV_IO_WRITE] = io_store_tally;
			expected_count[core_pkg::EV_IO_STALL] = stall_tally;
			creg_access($sformatf("counter %0d read", n),
				core_pkg::creg_idx_t'(core_pkg::CR_PERF_BASE + n), 1'b0, '0,
				expected_count[n]);
		end

		$display("Mismatches: %0d, protocol errors: %0d, timeouts: %0d",
			mismatch_count, protocol_count, timeout_count);
		if (mismatch_count + protocol_count + timeout_count == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

// File: vlog.f
design/core_pkg.sv
design/access_router.sv
design/control_registers.sv
design/io_request_fsm.sv
design/performance_counters.sv
design/core_uncore.sv
test/core_uncore_tb.sv
